//--- logic/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// boot address in kseg1
`define RESET_PC        32'hBFC00000
// general exception entry
`define GENERAL_EX_PC   32'hBFC00380

// branch target buffer geometry
`define BTB_ENTRIES     16
`define BTB_INDEX_W     4

// instruction cache sets, 16-byte lines
`define ICACHE_SETS     256

// exception codes, cp0 cause encoding
`define EXC_NONE        5'd0
`define EXC_ADEL        5'd4

`endif

//--- logic/fetch_types_pkg.sv
package fetch_types_pkg;

    // virtual byte address of an instruction
    typedef logic [31:0] pc_t;

    // address after segment translation
    typedef logic [31:0] paddr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // cp0 cause exccode field
    typedef logic [4:0] exc_code_t;

endpackage

//--- logic/icache_pkg.sv
package icache_pkg;

    // physical address split: tag 31:12, index 11:4, offset 3:0
    typedef logic [7:0]  cache_index_t;
    typedef logic [19:0] cache_tag_t;
    typedef logic [3:0]  cache_offset_t;

    // four words, word 0 in bits 31:0
    typedef logic [127:0] line_t;

    // four-phase refill sequence
    typedef enum logic [1:0] {
        idle,
        request,
        wait_release
    } refill_state_t;

endpackage

//--- logic/pre_if_stage.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module pre_if_stage import fetch_types_pkg::*, icache_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          fs_allowin,
    input  logic          flush,
    input  logic          br_flush,
    input  logic          eret,
    input  pc_t           epc,
    input  logic          br_valid,
    input  logic          br_pred_valid,
    input  logic          br_pred_right,
    input  logic          br_taken,
    input  pc_t           br_target,
    input  pc_t           br_pc,
    input  logic          pred_valid,
    input  pc_t           pred_target,
    input  logic          icache_busy,
    input  inst_t         inst_rdata,
    output pc_t           ps_pc,
    output logic          ps_valid,
    output logic          ps_inst_valid,
    output inst_t         ps_inst,
    output logic          ps_ex,
    output exc_code_t     ps_exccode,
    output logic          inst_valid,
    output cache_tag_t    inst_tag,
    output cache_index_t  inst_index,
    output cache_offset_t inst_offset
);

    pc_t    next_pc;
    pc_t    seq_pc;
    pc_t    pred_or_seq;
    paddr_t phys_addr;
    logic   pc_load;
    logic   adel;
    logic   req_ok;
    logic   flush_delayed;

    assign seq_pc      = ps_pc + 32'd4;
    assign pred_or_seq = pred_valid ? pred_target : seq_pc;

    always_comb begin
        if (eret) begin
            next_pc = epc;
        end else if (flush) begin
            next_pc = `GENERAL_EX_PC;
        end else if (br_valid && br_pred_valid) begin
            if (br_pred_right) begin
                next_pc = pred_or_seq;
            end else if (br_taken) begin
                next_pc = br_target;
            end else begin
                // mispredicted taken, resume after the delay slot
                next_pc = br_pc + 32'd8;
            end
        end else if (br_valid && br_taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pred_or_seq;
        end
    end

    // a flush always redirects, otherwise wait for the cache and fetch stage
    assign pc_load = flush | (~icache_busy & fs_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ps_pc <= `RESET_PC;
        end else if (pc_load) begin
            ps_pc <= next_pc;
        end
    end

    // set by flush, held until the first redirected request completes
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_delayed <= 1'b0;
        end else if (flush) begin
            flush_delayed <= 1'b1;
        end else if (~icache_busy) begin
            flush_delayed <= 1'b0;
        end
    end

    // kseg0 and kseg1 drop the top three bits, the rest is identity
    assign phys_addr = (ps_pc[31:30] == 2'b10) ? {3'b000, ps_pc[28:0]} : ps_pc;

    assign adel   = ps_pc[1:0] != 2'b00;
    assign req_ok = flush_delayed | ~br_flush;

    assign inst_valid  = req_ok & ~adel;
    assign inst_tag    = phys_addr[31:12];
    assign inst_index  = phys_addr[11:4];
    assign inst_offset = phys_addr[3:0];

    assign ps_valid      = ~icache_busy;
    assign ps_inst_valid = inst_valid;
    assign ps_inst       = inst_rdata;
    assign ps_ex         = adel & req_ok;
    assign ps_exccode    = adel ? `EXC_ADEL : `EXC_NONE;

    // pc is frozen for the whole of a refill unless an exception redirects it
    pc_held_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        icache_busy && !flush |=> $stable(ps_pc)
    );

endmodule

//--- logic/branch_predictor.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module branch_predictor import fetch_types_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  pc_t  ps_pc,
    input  logic br_valid,
    input  logic br_taken,
    input  pc_t  br_target,
    input  pc_t  br_pc,
    output logic pred_valid,
    output pc_t  pred_target
);

    // word index sits just above the byte offset
    localparam int TAG_LSB = `BTB_INDEX_W + 2;

    typedef logic [`BTB_INDEX_W-1:0] btb_index_t;
    typedef logic [31:TAG_LSB]       btb_tag_t;

    logic [`BTB_ENTRIES-1:0] btb_valid;
    btb_tag_t                btb_tag    [`BTB_ENTRIES];
    pc_t                     btb_target [`BTB_ENTRIES];

    btb_index_t lookup_idx;
    btb_tag_t   lookup_tag;
    btb_index_t update_idx;
    btb_tag_t   update_tag;
    logic       update_match;

    assign lookup_idx = ps_pc[TAG_LSB-1:2];
    assign lookup_tag = ps_pc[31:TAG_LSB];
    assign update_idx = br_pc[TAG_LSB-1:2];
    assign update_tag = br_pc[31:TAG_LSB];

    // lookup is purely combinational on the pre-fetch pc
    assign pred_valid  = btb_valid[lookup_idx] && (btb_tag[lookup_idx] == lookup_tag);
    assign pred_target = btb_target[lookup_idx];

    // only an entry for this very branch may be cleared
    assign update_match = btb_valid[update_idx] && (btb_tag[update_idx] == update_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (br_valid) begin
            if (br_taken) begin
                btb_valid[update_idx] <= 1'b1;
            end else if (update_match) begin
                btb_valid[update_idx] <= 1'b0;
            end
        end
    end

    // taken branches allocate or overwrite their slot
    always_ff @(posedge clk) begin
        if (br_valid && br_taken) begin
            btb_tag[update_idx]    <= update_tag;
            btb_target[update_idx] <= br_target;
        end
    end

endmodule

//--- logic/icache.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module icache import fetch_types_pkg::*, icache_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          inst_valid,
    input  cache_tag_t    inst_tag,
    input  cache_index_t  inst_index,
    input  cache_offset_t inst_offset,
    output logic          icache_busy,
    output inst_t         inst_rdata,
    output logic          mem_req,
    output paddr_t        mem_addr,
    input  logic          mem_ack,
    input  line_t         mem_line
);

    logic [`ICACHE_SETS-1:0] set_valid;
    cache_tag_t              tag_ram  [`ICACHE_SETS];
    line_t                   data_ram [`ICACHE_SETS];

    refill_state_t state;
    refill_state_t state_next;
    cache_tag_t    miss_tag;
    cache_index_t  miss_index;
    line_t         hit_line;
    logic          hit;
    logic          miss;
    logic          fill;

    assign hit_line = data_ram[inst_index];
    assign hit      = inst_valid && set_valid[inst_index] && (tag_ram[inst_index] == inst_tag);
    assign miss     = inst_valid && !hit;

    // word select from offset bits 3:2
    assign inst_rdata = hit_line[{inst_offset[3:2], 5'b00000} +: 32];

    // busy covers a fresh miss and every cycle of an open refill
    assign icache_busy = (state != idle) || miss;

    // line written on the ack edge
    assign fill = (state == request) && mem_ack;

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (miss) begin
                    state_next = request;
                end
            end
            request: begin
                if (mem_ack) begin
                    state_next = wait_release;
                end
            end
            wait_release: begin
                // memory must drop ack before the next request
                if (!mem_ack) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            set_valid <= '0;
        end else begin
            state <= state_next;
            if (fill) begin
                set_valid[miss_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && miss) begin
            miss_tag   <= inst_tag;
            miss_index <= inst_index;
        end
        if (fill) begin
            tag_ram[miss_index]  <= miss_tag;
            data_ram[miss_index] <= mem_line;
        end
    end

    assign mem_req  = (state == request);
    assign mem_addr = {miss_tag, miss_index, 4'b0000};

    refill_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req |=> !mem_req || $stable(mem_addr)
    );

    // req may only be released after memory answered
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (reset)
        mem_req && !mem_ack |=> mem_req
    );

endmodule

//--- logic/if_stage.sv
`timescale 1ns/100ps

module if_stage import fetch_types_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ps_valid,
    input  pc_t       ps_pc,
    input  logic      ps_inst_valid,
    input  inst_t     ps_inst,
    input  logic      ps_ex,
    input  exc_code_t ps_exccode,
    input  logic      flush,
    input  logic      br_flush,
    input  logic      ds_allowin,
    output logic      fs_allowin,
    output logic      fs_valid,
    output pc_t       fs_pc,
    output inst_t     fs_inst,
    output logic      fs_ex,
    output exc_code_t fs_exccode
);

    logic accept;

    // free when empty or when decode takes the held item this cycle
    assign fs_allowin = !fs_valid || ds_allowin;

    // only real fetches or exceptions enter the stage
    assign accept = ps_valid && fs_allowin && (ps_inst_valid || ps_ex);

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (flush) begin
            fs_valid <= 1'b0;
        end else if (accept) begin
            fs_valid <= 1'b1;
        end else if (br_flush || ds_allowin) begin
            // wrong-path item killed, or handed to decode
            fs_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fs_pc      <= ps_pc;
            fs_inst    <= ps_inst;
            fs_ex      <= ps_ex;
            fs_exccode <= ps_exccode;
        end
    end

    // stall from decode freezes the whole output set
    hold_under_stall: assert property (
        @(posedge clk) disable iff (reset)
        fs_valid && !ds_allowin && !flush && !br_flush
            |=> fs_valid && $stable(fs_pc) && $stable(fs_inst)
                && $stable(fs_ex) && $stable(fs_exccode)
    );

endmodule

//--- logic/fetch_frontend.sv
`timescale 1ns/100ps

module fetch_frontend import fetch_types_pkg::*, icache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      br_valid,
    input  logic      br_pred_valid,
    input  logic      br_pred_right,
    input  logic      br_taken,
    input  pc_t       br_target,
    input  pc_t       br_pc,
    input  logic      flush,
    input  logic      br_flush,
    input  logic      eret,
    input  pc_t       epc,
    input  logic      ds_allowin,
    output logic      fs_valid,
    output pc_t       fs_pc,
    output inst_t     fs_inst,
    output logic      fs_ex,
    output exc_code_t fs_exccode,
    output logic      mem_req,
    output paddr_t    mem_addr,
    input  logic      mem_ack,
    input  line_t     mem_line
);

    pc_t           ps_pc;
    logic          ps_valid;
    logic          ps_inst_valid;
    inst_t         ps_inst;
    logic          ps_ex;
    exc_code_t     ps_exccode;
    logic          fs_allowin;
    logic          pred_valid;
    pc_t           pred_target;
    logic          icache_busy;
    inst_t         inst_rdata;
    logic          inst_valid;
    cache_tag_t    inst_tag;
    cache_index_t  inst_index;
    cache_offset_t inst_offset;

    pre_if_stage u_pre_if (
        .clk           (clk),
        .reset         (reset),
        .fs_allowin    (fs_allowin),
        .flush         (flush),
        .br_flush      (br_flush),
        .eret          (eret),
        .epc           (epc),
        .br_valid      (br_valid),
        .br_pred_valid (br_pred_valid),
        .br_pred_right (br_pred_right),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .br_pc         (br_pc),
        .pred_valid    (pred_valid),
        .pred_target   (pred_target),
        .icache_busy   (icache_busy),
        .inst_rdata    (inst_rdata),
        .ps_pc         (ps_pc),
        .ps_valid      (ps_valid),
        .ps_inst_valid (ps_inst_valid),
        .ps_inst       (ps_inst),
        .ps_ex         (ps_ex),
        .ps_exccode    (ps_exccode),
        .inst_valid    (inst_valid),
        .inst_tag      (inst_tag),
        .inst_index    (inst_index),
        .inst_offset   (inst_offset)
    );

    branch_predictor u_bp (
        .clk         (clk),
        .reset       (reset),
        .ps_pc       (ps_pc),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .br_pc       (br_pc),
        .pred_valid  (pred_valid),
        .pred_target (pred_target)
    );

    icache u_icache (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_tag    (inst_tag),
        .inst_index  (inst_index),
        .inst_offset (inst_offset),
        .icache_busy (icache_busy),
        .inst_rdata  (inst_rdata),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_line    (mem_line)
    );

    if_stage u_if (
        .clk           (clk),
        .reset         (reset),
        .ps_valid      (ps_valid),
        .ps_pc         (ps_pc),
        .ps_inst_valid (ps_inst_valid),
        .ps_inst       (ps_inst),
        .ps_ex         (ps_ex),
        .ps_exccode    (ps_exccode),
        .flush         (flush),
        .br_flush      (br_flush),
        .ds_allowin    (ds_allowin),
        .fs_allowin    (fs_allowin),
        .fs_valid      (fs_valid),
        .fs_pc         (fs_pc),
        .fs_inst       (fs_inst),
        .fs_ex         (fs_ex),
        .fs_exccode    (fs_exccode)
    );

endmodule

//--- verification/fetch_tb_memory.sv
`timescale 1ns/100ps

module fetch_tb_memory import fetch_types_pkg::*, icache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       mem_req,
    input  paddr_t     mem_addr,
    input  logic [2:0] delay_pick,
    output logic       mem_ack,
    output line_t      mem_line
);

    int   wait_left;
    logic counting;

    // each word holds its own physical address inverted
    function automatic line_t build_line(paddr_t addr);
        line_t  line;
        paddr_t base;
        base = {addr[31:4], 4'h0};
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = ~(base + 32'(w * 4));
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            mem_ack   <= 1'b0;
            counting  <= 1'b0;
            wait_left <= 0;
            mem_line  <= '0;
        end else if (mem_ack) begin
            // release phase
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req) begin
            if (!counting) begin
                counting  <= 1'b1;
                wait_left <= int'(delay_pick);
            end else if (wait_left == 0) begin
                counting <= 1'b0;
                mem_ack  <= 1'b1;
                mem_line <= build_line(mem_addr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule

//--- verification/fetch_frontend_tb.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_frontend_tb import fetch_types_pkg::*, icache_pkg::*;;

    // seven tests of at most 2500 cycles each, plus margin
    localparam int CYCLE_LIMIT = 7 * 2500 + 2500;
    localparam pc_t LEARN_PC = 32'hBFC00020;
    localparam pc_t LEARN_TGT = 32'hBFC00080;

    logic clk, reset, br_valid, br_pred_valid, br_pred_right, br_taken;
    logic flush, br_flush, eret, ds_allowin, fs_valid, fs_ex, mem_req, mem_ack;
    pc_t br_target, br_pc, epc, fs_pc;
    inst_t fs_inst;
    exc_code_t fs_exccode;
    paddr_t mem_addr;
    line_t mem_line;
    logic [2:0] delay_pick;
    logic [31:0] lfsr;
    int errors, cycles, tests_run, tests_failed, err_at_start;

    // reference model state
    pc_t ref_pc, exp_fs_pc;
    logic ref_fs_valid;
    logic [15:0] btb_v;
    pc_t btb_pc [16];
    pc_t btb_tgt [16];
    logic [255:0] line_v;
    logic [19:0] line_tag [256];

    fetch_frontend uut (.*);
    fetch_tb_memory u_mem (.clk, .reset, .mem_req, .mem_addr, .delay_pick, .mem_ack, .mem_line);

    function automatic paddr_t to_phys(pc_t pc);
        return (pc[31:30] == 2'b10) ? {3'b000, pc[28:0]} : pc;
    endfunction

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random stall about a quarter of the time, and the memory delay
    always @(posedge clk) begin
        logic [31:0] s;
        logic [4:0] bits;
        s = lfsr;
        for (int b = 0; b < 5; b++) begin
            s = lfsr_step(s);
            bits[b] = s[0];
        end
        lfsr <= s;
        ds_allowin <= (bits[1:0] != 2'b00);
        delay_pick <= bits[4:2];
    end

    always @(posedge clk) begin
        logic hit;
        logic take;
        pc_t pos, nxt;
        cycles <= cycles + 1;
        if (reset) begin
            ref_pc <= `RESET_PC;
            ref_fs_valid <= 1'b0;
            btb_v <= '0;
            line_v <= '0;
        end else begin
            hit = btb_v[ref_pc[5:2]] && (btb_pc[ref_pc[5:2]] == ref_pc);
            pos = hit ? btb_tgt[ref_pc[5:2]] : ref_pc + 32'd4;
            if (eret) nxt = epc;
            else if (flush) nxt = `GENERAL_EX_PC;
            else if (br_valid && br_pred_valid && !br_pred_right)
                nxt = br_taken ? br_target : br_pc + 32'd8;
            else if (br_valid && !br_pred_valid && br_taken) nxt = br_target;
            else nxt = pos;
            // fetch stage takes an item when empty or draining into decode
            take = uut.ps_valid && (!ref_fs_valid || ds_allowin);
            if (flush || take) ref_pc <= nxt;
            if (flush) begin
                ref_fs_valid <= 1'b0;
            end else if (take && !br_flush) begin
                ref_fs_valid <= 1'b1;
                exp_fs_pc <= ref_pc;
            end else if (br_flush || ds_allowin) begin
                ref_fs_valid <= 1'b0;
            end
            if (br_valid && br_taken) begin
                btb_v[br_pc[5:2]] <= 1'b1;
                btb_pc[br_pc[5:2]] <= br_pc;
                btb_tgt[br_pc[5:2]] <= br_target;
            end else if (br_valid && btb_v[br_pc[5:2]] && btb_pc[br_pc[5:2]] == br_pc) begin
                btb_v[br_pc[5:2]] <= 1'b0;
            end
            if (mem_req && mem_ack) begin
                line_v[mem_addr[11:4]] <= 1'b1;
                line_tag[mem_addr[11:4]] <= mem_addr[31:12];
            end
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run passed the limit of %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    fs_valid_match: assert property (@(posedge clk) disable iff (reset)
        fs_valid == ref_fs_valid)
        else log_mismatch($sformatf("fs_valid %0b, expected %0b",
                                    $sampled(fs_valid), $sampled(ref_fs_valid)));
    fs_pc_match: assert property (@(posedge clk) disable iff (reset)
        fs_valid |-> fs_pc == exp_fs_pc)
        else log_mismatch($sformatf("fs_pc %h, expected %h",
                                    $sampled(fs_pc), $sampled(exp_fs_pc)));
    inst_data: assert property (@(posedge clk) disable iff (reset)
        fs_valid && !fs_ex |-> fs_inst == ~to_phys(exp_fs_pc))
        else log_mismatch($sformatf("fs_inst %h at pc %h",
                                    $sampled(fs_inst), $sampled(exp_fs_pc)));
    adel_flag: assert property (@(posedge clk) disable iff (reset)
        fs_valid |-> (fs_ex == (exp_fs_pc[1:0] != 2'b00))
            && (!fs_ex || fs_exccode == `EXC_ADEL))
        else log_mismatch($sformatf("exception %0b/%0d at pc %h",
                                    $sampled(fs_ex), $sampled(fs_exccode),
                                    $sampled(exp_fs_pc)));
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        fs_valid && !ds_allowin && !flush && !br_flush
            |=> fs_valid && $stable(fs_pc) && $stable(fs_inst))
        else log_mismatch("fs outputs moved under stall");
    req_addr: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> mem_addr == ($past(to_phys(ref_pc)) & 32'hFFFF_FFF0))
        else log_mismatch($sformatf("mem_addr %h not the missing line", $sampled(mem_addr)));
    no_refetch: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !(line_v[mem_addr[11:4]] && line_tag[mem_addr[11:4]] == mem_addr[31:12]))
        else log_mismatch($sformatf("refill of resident line %h", $sampled(mem_addr)));
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_ack) |-> mem_req)
        else log_mismatch("mem_ack rose without mem_req");
    req_drops_on_ack: assert property (@(posedge clk) disable iff (reset)
        mem_ack && mem_req |=> !mem_req)
        else log_mismatch("mem_req held after mem_ack");
    no_req_in_release: assert property (@(posedge clk) disable iff (reset)
        mem_ack |-> !$rose(mem_req))
        else log_mismatch("mem_req rose before release");

    // next item handed to decode
    task automatic next_taken(output pc_t pc, output bit ok);
        ok = 0;
        for (int c = 0; c < 200 && !ok; c++) begin
            @(posedge clk);
            if (fs_valid && ds_allowin) begin
                ok = 1;
                pc = fs_pc;
            end
        end
        if (!ok) begin
            errors++;
            $display("no item reached decode within 200 cycles");
        end
    endtask

    task automatic wait_fetch(input pc_t pc, input int items, output bit seen);
        pc_t got;
        bit ok;
        seen = 0;
        for (int i = 0; i < items && !seen; i++) begin
            next_taken(got, ok);
            if (ok && got == pc) seen = 1;
        end
    endtask

    task automatic redirect(input logic is_flush, input pc_t ret_pc, input pc_t expect_pc);
        bit seen;
        @(posedge clk);
        // an exception return always comes with the pipeline flush
        flush <= 1'b1;
        eret <= ~is_flush;
        epc <= ret_pc;
        @(posedge clk);
        flush <= 1'b0;
        eret <= 1'b0;
        wait_fetch(expect_pc, 4, seen);
        if (!seen) begin
            errors++;
            $display("no fetch of %h after the redirect", expect_pc);
        end
    endtask

    task automatic resolve_branch(input logic pv, input logic taken, input pc_t bpc,
                                  input pc_t tgt, input pc_t expect_pc, input logic kill);
        bit seen;
        seen = 0;
        for (int t = 0; t < 8 && !seen; t++) begin
            @(posedge clk);
            br_valid <= 1'b1;
            br_pred_valid <= pv;
            br_pred_right <= 1'b0;
            br_taken <= taken;
            br_pc <= bpc;
            br_target <= tgt;
            br_flush <= kill;
            @(posedge clk);
            br_valid <= 1'b0;
            br_flush <= 1'b0;
            wait_fetch(expect_pc, 30, seen);
        end
        if (!seen) begin
            errors++;
            $display("branch never redirected fetch to %h", expect_pc);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
        err_at_start = errors;
    endtask

    initial begin
        pc_t got;
        bit ok;
        {br_valid, br_pred_valid, br_pred_right, br_taken, flush, br_flush, eret} = '0;
        {br_target, br_pc, epc} = '0;
        lfsr = 32'ha31d9d31;
        ds_allowin = 1'b1;
        delay_pick = 3'd0;
        {errors, cycles, tests_run, tests_failed, err_at_start} = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        next_taken(got, ok);
        if (!ok || got != `RESET_PC) begin
            errors++;
            $display("first fetch after reset was not the boot address");
        end
        for (int i = 0; i < 64; i++) next_taken(got, ok);
        end_test("boot_sequential");
        redirect(1'b0, `RESET_PC, `RESET_PC);
        for (int i = 0; i < 64; i++) next_taken(got, ok);
        end_test("refill_refetch");
        redirect(1'b1, 32'h0, `GENERAL_EX_PC);
        redirect(1'b0, 32'hBFC00100, 32'hBFC00100);
        end_test("flush_eret");
        redirect(1'b0, 32'hBFC00202, 32'hBFC00202);
        redirect(1'b1, 32'h0, `GENERAL_EX_PC);
        end_test("misaligned_epc");
        resolve_branch(1'b1, 1'b1, 32'hBFC00200, 32'hBFC00040, 32'hBFC00040, 1'b0);
        resolve_branch(1'b1, 1'b0, 32'hBFC00304, 32'hBFC00400, 32'hBFC0030C, 1'b0);
        resolve_branch(1'b1, 1'b1, 32'hBFC00500, 32'hBFC00600, 32'hBFC00600, 1'b1);
        end_test("branch_correction");
        resolve_branch(1'b0, 1'b1, LEARN_PC, LEARN_TGT, LEARN_TGT, 1'b0);
        redirect(1'b0, 32'hBFC00014, LEARN_PC);
        next_taken(got, ok);
        if (!ok || got != LEARN_TGT) begin
            errors++;
            $display("learned branch target was not fetched after the branch");
        end
        end_test("prediction");
        for (int i = 0; i < 300; i++) next_taken(got, ok);
        end_test("back_pressure");
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- fetch_frontend.f
+incdir+logic
logic/fetch_types_pkg.sv
logic/icache_pkg.sv
logic/pre_if_stage.sv
logic/branch_predictor.sv
logic/icache.sv
logic/if_stage.sv
logic/fetch_frontend.sv
verification/fetch_tb_memory.sv
verification/fetch_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_frontend_tb \
    -f fetch_frontend.f -o fetch_sim > build.log 2>&1 \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
